// ==== files.f ====
source/square_reg_pkg.sv
source/square_seq_pkg.sv
source/square_freq_reg.sv
source/square_sweep.sv
source/square_freq_counter.sv
source/square_waveform.sv
source/envelope_unit.sv
source/square_chan.sv
test/square_chan_sva.sv
test/square_chan_tb.sv

// ==== source/envelope_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

/* Envelope generator
   Decaying level clocked by quarter frames, or a constant volume */
module envelope_unit (
	input wire aclk,
	input wire rst_n,
	input wire [7:0] db,
	input wire wr0,
	input wire wr3,
	input wire quarter_frame,
	output square_reg_pkg::vol_t volume,
	output logic sq_lc
);

	import square_reg_pkg::*;

	logic const_vol;
	vol_t vol_field;
	logic start;
	vol_t divider;
	vol_t decay;

	assign volume = const_vol ? vol_field : decay;

	// sq_lc doubles as the envelope loop flag
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			sq_lc <= 1'b0;
			const_vol <= 1'b0;
			vol_field <= '0;
			start <= 1'b0;
			divider <= '0;
			decay <= '0;
		end else begin
			if (wr0) begin
				sq_lc <= db[halt_bit];
				const_vol <= db[const_bit];
				vol_field <= db[vol_msb:vol_lsb];
			end
			if (quarter_frame) begin
				start <= 1'b0;
				if (start) begin
					decay <= 4'hf;
					divider <= vol_field;
				end else if (divider == '0) begin
					divider <= vol_field;
					if (decay != '0) begin
						decay <= decay - 1'b1;
					end else if (sq_lc) begin
						decay <= 4'hf; // Loop
					end
				end else begin
					divider <= divider - 1'b1;
				end
			end
			if (wr3) begin
				start <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/square_chan.sv ====
`timescale 1ns/10ps
`default_nettype none

/* Square wave channel
   Period, sweep, timer, duty sequencer and envelope tied together */
module square_chan #(
	parameter bit sweep_ones_complement = 1'b1 // 1 for the first channel
) (
	input wire aclk,
	input wire rst_n,
	input wire [7:0] db,
	input wire wr0,
	input wire wr1,
	input wire wr2,
	input wire wr3,
	input wire quarter_frame,
	input wire half_frame,
	input wire nosq,
	input wire lock,
	output logic sq_lc,
	output square_reg_pkg::vol_t sq_out
);

	import square_reg_pkg::*;

	period_t period;
	period_t target;
	logic sweep_load;
	logic sweep_mute;
	logic timer_tick;
	vol_t volume;

	square_freq_reg i_freq_reg (
		.aclk(aclk), .rst_n(rst_n), .db(db), .wr2(wr2), .wr3(wr3),
		.sweep_load(sweep_load), .target(target), .period(period)
	);

	square_sweep #(.sweep_ones_complement(sweep_ones_complement)) i_sweep (
		.aclk(aclk), .rst_n(rst_n), .db(db), .wr1(wr1), .half_frame(half_frame),
		.nosq(nosq), .period(period), .target(target), .sweep_load(sweep_load),
		.sweep_mute(sweep_mute)
	);

	square_freq_counter i_freq_counter (
		.aclk(aclk), .rst_n(rst_n), .period(period), .timer_tick(timer_tick)
	);

	square_waveform i_waveform (
		.aclk(aclk), .rst_n(rst_n), .db(db), .wr0(wr0), .wr3(wr3),
		.timer_tick(timer_tick), .sweep_mute(sweep_mute), .nosq(nosq), .lock(lock),
		.volume(volume), .sq_out(sq_out)
	);

	envelope_unit i_envelope (
		.aclk(aclk), .rst_n(rst_n), .db(db), .wr0(wr0), .wr3(wr3),
		.quarter_frame(quarter_frame), .volume(volume), .sq_lc(sq_lc)
	);

endmodule

`default_nettype wire

// ==== source/square_freq_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

/* Square frequency timer
   Counts down from the period and ticks once per period plus one cycles */
module square_freq_counter (
	input wire aclk,
	input wire rst_n,
	input wire square_reg_pkg::period_t period,
	output logic timer_tick
);

	import square_reg_pkg::*;

	period_t count;
	period_t count_next;

	assign count_next = (count == '0) ? period : count - 1'b1;

	// Tick is registered so it lines up with the zero count
	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			timer_tick <= 1'b0;
		end else begin
			count <= count_next;
			timer_tick <= (count_next == '0);
		end
	end

endmodule

`default_nettype wire

// ==== source/square_freq_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

/* Square period register
   Loaded by CPU writes to registers 2 and 3, or by a sweep update */
module square_freq_reg (
	input wire aclk,
	input wire rst_n,
	input wire [7:0] db,
	input wire wr2,
	input wire wr3,
	input wire sweep_load,
	input wire square_reg_pkg::period_t target,
	output square_reg_pkg::period_t period
);

	import square_reg_pkg::*;

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			period <= '0;
		end else if (wr2 || wr3) begin // CPU has priority over sweep
			if (wr2) begin
				period[7:0] <= db;
			end
			if (wr3) begin
				period[10:8] <= db[period_hi_msb:period_hi_lsb];
			end
		end else if (sweep_load) begin
			period <= target;
		end
	end

endmodule

`default_nettype wire

// ==== source/square_reg_pkg.sv ====
`default_nettype none

/* Square channel register map
   Field types and their bit positions on the CPU data bus */
package square_reg_pkg;

	typedef logic [10:0] period_t;    // Timer period
	typedef logic [2:0]  shift_t;     // Sweep shift count
	typedef logic [3:0]  vol_t;       // Volume or envelope level
	typedef logic [1:0]  duty_sel_t;
	typedef logic [2:0]  sweep_div_t; // Sweep divider period

	// Register 0
	localparam int duty_msb = 7;
	localparam int duty_lsb = 6;
	localparam int halt_bit = 5;
	localparam int const_bit = 4;
	localparam int vol_msb = 3;
	localparam int vol_lsb = 0;

	// Register 1
	localparam int sweep_en_bit = 7;
	localparam int sweep_div_msb = 6;
	localparam int sweep_div_lsb = 4;
	localparam int negate_bit = 3;
	localparam int shift_msb = 2;
	localparam int shift_lsb = 0;

	localparam int period_hi_msb = 2; // Register 3
	localparam int period_hi_lsb = 0;

endpackage

`default_nettype wire

// ==== source/square_seq_pkg.sv ====
`default_nettype none

/* Square channel sequencing constants
   Duty patterns, sequencer step type and the mute threshold */
package square_seq_pkg;

	localparam int step_w = 3;

	typedef logic [step_w-1:0] step_t;

	// Step 0 reads the MSB of each pattern
	localparam logic [3:0][7:0] duty_table = {
		8'b10011111, // 75%, inverted 25%
		8'b01111000, // 50%
		8'b01100000, // 25%
		8'b01000000  // 12.5%
	};

	localparam int unsigned min_period = 8; // Lower periods are inaudible

endpackage

`default_nettype wire

// ==== source/square_sweep.sv ====
`timescale 1ns/10ps
`default_nettype none

/* Square sweep unit
   Shifter and adder build the target period, divider paces the updates */
module square_sweep #(
	parameter bit sweep_ones_complement = 1'b1
) (
	input wire aclk,
	input wire rst_n,
	input wire [7:0] db,
	input wire wr1,
	input wire half_frame,
	input wire nosq,
	input wire square_reg_pkg::period_t period,
	output square_reg_pkg::period_t target,
	output logic sweep_load,
	output logic sweep_mute
);

	import square_reg_pkg::*;
	import square_seq_pkg::*;

	logic sweep_en;
	logic negate;
	sweep_div_t div_period;
	shift_t shift;
	sweep_div_t div_cnt;
	logic reload;

	period_t change;
	period_t addend;
	logic carry_in;
	logic [11:0] sum;

	assign change = period >> shift;
	assign addend = negate ? ~change : change;
	assign carry_in = negate && !sweep_ones_complement; // Two's complement negate
	assign sum = {1'b0, period} + {1'b0, addend} + 12'(carry_in);
	assign target = sum[10:0];

	// Carry out only means overflow when adding
	assign sweep_mute = (period < min_period) || (!negate && sum[11]);

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			sweep_en <= 1'b0;
			negate <= 1'b0;
			div_period <= '0;
			shift <= '0;
			div_cnt <= '0;
			reload <= 1'b0;
			sweep_load <= 1'b0;
		end else begin
			sweep_load <= half_frame && (div_cnt == '0) && sweep_en && (shift != '0) &&
				!sweep_mute && !nosq;
			if (half_frame) begin
				reload <= 1'b0;
				if (div_cnt == '0 || reload) begin
					div_cnt <= div_period;
				end else begin
					div_cnt <= div_cnt - 1'b1;
				end
			end
			if (wr1) begin
				sweep_en <= db[sweep_en_bit];
				div_period <= db[sweep_div_msb:sweep_div_lsb];
				negate <= db[negate_bit];
				shift <= db[shift_msb:shift_lsb];
				reload <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/square_waveform.sv ====
`timescale 1ns/10ps
`default_nettype none

/* Square duty sequencer and output stage
   Steps through the duty pattern and gates the volume onto sq_out */
module square_waveform (
	input wire aclk,
	input wire rst_n,
	input wire [7:0] db,
	input wire wr0,
	input wire wr3,
	input wire timer_tick,
	input wire sweep_mute,
	input wire nosq,
	input wire lock,
	input wire square_reg_pkg::vol_t volume,
	output square_reg_pkg::vol_t sq_out
);

	import square_reg_pkg::*;
	import square_seq_pkg::*;

	duty_sel_t duty;
	step_t step;
	logic [7:0] pattern;
	logic duty_bit;

	assign pattern = duty_table[duty];
	assign duty_bit = pattern[~step]; // Step 0 is the MSB

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			duty <= '0;
			step <= '0;
		end else begin
			if (wr0) begin
				duty <= db[duty_msb:duty_lsb];
			end
			if (wr3) begin
				step <= '0; // Restart waveform
			end else if (timer_tick) begin
				step <= step + 1'b1;
			end
		end
	end

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			sq_out <= '0;
		end else if (duty_bit && !sweep_mute && !nosq && !lock) begin
			sq_out <= volume;
		end else begin
			sq_out <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== test/square_chan_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

/* Square channel assertions
   Timer tick spacing, sweep load against mute, and lock gating of the output */
module square_chan_sva (
	input wire aclk,
	input wire rst_n,
	input wire square_reg_pkg::period_t period,
	input wire timer_tick,
	input wire sweep_load,
	input wire sweep_mute,
	input wire lock,
	input wire square_reg_pkg::vol_t sq_out
);

	import square_reg_pkg::*;
	import square_seq_pkg::*;

	period_t since_tick;
	period_t prev_period;
	logic steady; // Period unchanged since the last tick

	always_ff @(posedge aclk or negedge rst_n) begin
		if (!rst_n) begin
			since_tick <= '0;
			prev_period <= '0;
			steady <= 1'b0;
		end else begin
			prev_period <= period;
			if (timer_tick) begin
				since_tick <= '0;
				steady <= 1'b1;
			end else begin
				since_tick <= since_tick + 1'b1;
				if (period != prev_period) begin
					steady <= 1'b0;
				end
			end
		end
	end

	assert property (@(posedge aclk) disable iff (!rst_n)
		timer_tick && steady && (period == prev_period) |-> since_tick == period)
		else $error("timer_tick spacing differs from period plus one");

	assert property (@(posedge aclk) disable iff (!rst_n)
		sweep_load |-> !sweep_mute && (period >= min_period))
		else $error("sweep_load while the channel is muted");

	assert property (@(posedge aclk) disable iff (!rst_n)
		lock |=> sq_out == '0)
		else $error("sq_out nonzero one cycle after lock");

endmodule

bind square_chan square_chan_sva i_sva (
	.aclk(aclk), .rst_n(rst_n), .period(period), .timer_tick(timer_tick),
	.sweep_load(sweep_load), .sweep_mute(sweep_mute), .lock(lock), .sq_out(sq_out)
);

`default_nettype wire

// ==== test/square_chan_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

/* Square channel testbench
   Replays register writes and frame pulses from a vector file and checks sq_out */
module square_chan_tb;

	import square_reg_pkg::*;

	localparam int drive_delay = 1;
	localparam int wait_limit = 20000; // Cycles
	localparam int rand_seed = 8158;

	logic aclk;
	logic rst_n;
	logic [7:0] db;
	logic wr0;
	logic wr1;
	logic wr2;
	logic wr3;
	logic quarter_frame;
	logic half_frame;
	logic nosq;
	logic lock;
	logic sq_lc;
	vol_t sq_out;
	int last_level; // Level confirmed by the latest V command

	square_chan #(.sweep_ones_complement(1'b1)) i_dut (
		.aclk(aclk), .rst_n(rst_n), .db(db), .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
		.quarter_frame(quarter_frame), .half_frame(half_frame), .nosq(nosq), .lock(lock),
		.sq_lc(sq_lc), .sq_out(sq_out)
	);

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input int got, input int expected, input string what);
		if (got != expected) begin
			$display("Fail at %0t: %s, expected %0d, got %0d", $time, what, expected, got);
			stop_run();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: no %s within %0d cycles", $time, what, wait_limit);
		stop_run();
	endtask

	task automatic next_cycle();
		@(posedge aclk);
		#drive_delay;
	endtask

	task automatic idle_gap();
		int n;
		n = 1 + ($urandom % 4);
		repeat (n) next_cycle();
	endtask

	task automatic write_reg(input int index, input logic [7:0] data);
		db = data;
		{wr3, wr2, wr1, wr0} = 4'b0001 << index;
		next_cycle();
		{wr3, wr2, wr1, wr0} = 4'b0000;
		if (index == 0) begin
			check_value(sq_lc, data[halt_bit], "sq_lc after register 0 write");
		end
	endtask

	task automatic count_active(input int len, input int expected);
		int count;
		count = 0;
		repeat (len) begin
			next_cycle();
			if (sq_out != '0) begin
				count++;
				check_value(sq_out, last_level, "nonzero sq_out level in window");
			end
		end
		check_value(count, expected, "nonzero sq_out cycles in window");
	endtask

	task automatic hold_zero(input int len);
		repeat (len) begin
			next_cycle();
			check_value(sq_out, 0, "sq_out while muted");
		end
	endtask

	task automatic wait_level(input int expected);
		int waited;
		waited = 0;
		while (sq_out == '0) begin
			if (waited == wait_limit) report_timeout("nonzero sq_out");
			next_cycle();
			waited++;
		end
		check_value(sq_out, expected, "sq_out level");
		last_level = expected;
	endtask

	task automatic wait_rise(output int cycles);
		logic was_zero;
		cycles = 0;
		do begin
			if (cycles == wait_limit) report_timeout("rising edge on sq_out");
			was_zero = (sq_out == '0);
			next_cycle();
			cycles++;
		end while (!was_zero || sq_out == '0);
	endtask

	initial begin
		int fd;
		int a;
		int b;
		int cycles;
		byte cmd;
		string line;
		void'($urandom(rand_seed));
		last_level = 0;
		rst_n = 1'b0;
		db = '0;
		{wr3, wr2, wr1, wr0} = 4'b0000;
		quarter_frame = 1'b0;
		half_frame = 1'b0;
		nosq = 1'b0;
		lock = 1'b0;
		repeat (3) @(posedge aclk);
		#drive_delay;
		rst_n = 1'b1;
		check_value(sq_lc, 0, "sq_lc after reset");
		fd = $fopen("test/square_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file test/square_vectors.txt");
			stop_run();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") continue;
			cmd = line[0];
			a = 0;
			b = 0;
			if (cmd == "W") void'($sscanf(line, "%c %d %h", cmd, a, b));
			else void'($sscanf(line, "%c %d %d", cmd, a, b));
			case (cmd)
				"W": write_reg(a, b[7:0]);
				"Q": begin
					repeat (a) begin
						quarter_frame = 1'b1;
						next_cycle();
						quarter_frame = 1'b0;
						next_cycle();
					end
				end
				"H": begin
					half_frame = 1'b1;
					next_cycle();
					half_frame = 1'b0;
				end
				"N": nosq = a[0];
				"L": lock = a[0];
				"M": count_active(a, b);
				"P": begin
					wait_rise(cycles);
					wait_rise(cycles);
					check_value(cycles, a, "cycles between rising edges of sq_out");
				end
				"V": wait_level(a);
				"Z": hold_zero(a);
				default: begin
					$display("Unknown command in vector file: %s", line);
					stop_run();
				end
			endcase
			idle_gap();
		end
		$fclose(fd);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/square_vectors.txt ====
# Columns: command letter, then up to two fields; W takes register (decimal), data (hex)
# W write, Q quarter pulses, H half pulse, N nosq, L lock, M window count, P spacing, V level, Z zero
Z 20
W 0 99
W 2 64
W 3 00
V 9
M 808 404
W 0 19
M 808 101
W 0 59
M 808 202
W 0 d9
M 808 606
W 0 99
P 808
W 2 2c
W 3 01
P 2408
W 2 c8
W 3 00
W 1 81
H
P 2408
W 2 c8
W 3 00
W 1 89
H
P 800
W 0 d9
W 1 81
W 2 05
Z 200
W 2 f0
W 3 07
Z 300
W 2 64
W 3 00
N 1
Z 900
N 0
V 9
L 1
Z 900
L 0
V 9
W 0 c0
W 3 00
Q 1
V 15
Q 1
V 14
Q 1
V 13
W 0 e0
Q 13
Z 900
Q 1
V 15
